/* verilog/eth_fcs_pkg.sv */
// Widths are fixed at 64 data bits and 8 byte lanes; keep is contiguous from lane 0
`default_nettype none

package eth_fcs_pkg;

    // datapath geometry
    localparam int data_w = 64;
    localparam int lanes = data_w / 8;

    // ethernet CRC-32 in reflected form
    localparam logic [31:0] crc_poly = 32'hEDB8_8320;
    localparam logic [31:0] crc_init = 32'hFFFF_FFFF;

    // FCS length in bytes
    localparam int fcs_bytes = 4;

    // one data beat
    typedef logic [data_w-1:0] beat_t;

    // byte enable, bit i covers byte i
    typedef logic [lanes-1:0] keep_t;

    // CRC state or FCS value
    typedef logic [31:0] crc_t;

    typedef enum logic [1:0] {
        st_idle,
        st_payload,
        st_fcs
    } fcs_state_t;

endpackage

`default_nettype wire

/* verilog/fcs_crc_engine.sv */
// Expects masked data with contiguous keep; restart takes priority over update
`default_nettype none
`timescale 1ns/1ns

module fcs_crc_engine (
    input  wire                      clk,
    input  wire                      rst,
    input  wire eth_fcs_pkg::beat_t  crc_data,
    input  wire eth_fcs_pkg::keep_t  crc_keep,
    input  wire                      crc_update,
    input  wire                      crc_restart,
    output eth_fcs_pkg::crc_t        fcs
);
    import eth_fcs_pkg::*;

    crc_t crc_state;
    crc_t stage [lanes+1];
    crc_t crc_last;

    // one reflected CRC step over a single byte taken lsb first
    function automatic crc_t crc_byte(crc_t c_in, logic [7:0] b);
        crc_t c;
        c = c_in ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // cascade over the lanes
    always_comb begin
        stage[0] = crc_state;
        for (int i = 0; i < lanes; i++) begin
            stage[i+1] = crc_byte(stage[i], crc_data[i*8 +: 8]);
        end
    end

    // state after the last enabled byte
    always_comb begin
        crc_last = crc_state;
        for (int i = 0; i < lanes; i++) begin
            if (crc_keep[i]) begin
                crc_last = stage[i+1];
            end
        end
    end

    assign fcs = ~crc_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_state <= crc_init;
        end else if (crc_restart) begin
            crc_state <= crc_init;
        end else if (crc_update) begin
            crc_state <= crc_last;
        end
    end

endmodule

`default_nettype wire

/* verilog/fcs_place.sv */
// Purely combinational; bytes above the last enabled lane of crc_data must already be zero
`default_nettype none
`timescale 1ns/1ns

module fcs_place (
    input  wire eth_fcs_pkg::beat_t  crc_data,
    input  wire eth_fcs_pkg::keep_t  crc_keep,
    input  wire eth_fcs_pkg::crc_t   fcs,
    output eth_fcs_pkg::beat_t       word0,
    output eth_fcs_pkg::beat_t       word1,
    output eth_fcs_pkg::keep_t       keep0,
    output eth_fcs_pkg::keep_t       keep1
);
    import eth_fcs_pkg::*;

    logic [3:0]           n_bytes;
    logic [6:0]           n_bits;
    logic [2*data_w-1:0]  wide_data;
    logic [2*lanes-1:0]   wide_keep;

    // count of valid bytes
    always_comb begin
        n_bytes = 4'd0;
        for (int i = 0; i < lanes; i++) begin
            if (crc_keep[i]) begin
                n_bytes = 4'(i + 1);
            end
        end
    end

    assign n_bits = {n_bytes, 3'b000};

    // fcs lands right after the data, lsb first, and may run into the second word
    assign wide_data = {{data_w{1'b0}}, crc_data}
                     | ({{(2*data_w-32){1'b0}}, fcs} << n_bits);

    assign wide_keep = {{lanes{1'b0}}, crc_keep}
                     | ({{(2*lanes-fcs_bytes){1'b0}}, {fcs_bytes{1'b1}}} << n_bytes);

    assign word0 = wide_data[data_w-1:0];
    assign word1 = wide_data[2*data_w-1:data_w];
    assign keep0 = wide_keep[lanes-1:0];
    assign keep1 = wide_keep[2*lanes-1:lanes];

endmodule

`default_nettype wire

/* verilog/fcs_frame_ctrl.sv */
// Assumes in_keep is contiguous from lane 0; no padding so short frames leave short
`default_nettype none
`timescale 1ns/1ns

module fcs_frame_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire eth_fcs_pkg::beat_t  in_data,
    input  wire eth_fcs_pkg::keep_t  in_keep,
    input  wire                      in_valid,
    input  wire                      in_last,
    input  wire                      in_user,
    output logic                     in_ready,
    output logic                     busy,
    input  wire                      accept,
    input  wire                      accept_early,
    input  wire eth_fcs_pkg::beat_t  fcs_word0,
    input  wire eth_fcs_pkg::keep_t  fcs_keep0,
    input  wire eth_fcs_pkg::beat_t  fcs_word1,
    input  wire eth_fcs_pkg::keep_t  fcs_keep1,
    output eth_fcs_pkg::beat_t       crc_data,
    output eth_fcs_pkg::keep_t       crc_keep,
    output logic                     crc_update,
    output logic                     crc_restart,
    output eth_fcs_pkg::beat_t       beat_data,
    output eth_fcs_pkg::keep_t       beat_keep,
    output logic                     beat_valid,
    output logic                     beat_last,
    output logic                     beat_user
);
    import eth_fcs_pkg::*;

    fcs_state_t state;
    fcs_state_t state_next;
    logic       ready_next;
    logic       spill_load;
    logic       xfer;
    beat_t      data_masked;
    beat_t      spill_data;
    keep_t      spill_keep;

    assign xfer = in_valid && in_ready;

    // zero the lanes that are not enabled
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            data_masked[i*8 +: 8] = in_keep[i] ? in_data[i*8 +: 8] : 8'd0;
        end
    end

    assign crc_data = data_masked;
    assign crc_keep = in_keep;

    always_comb begin
        state_next = state;
        ready_next = accept_early;
        spill_load = 1'b0;
        crc_update = 1'b0;
        crc_restart = 1'b0;
        beat_data = data_masked;
        beat_keep = in_keep;
        beat_valid = 1'b0;
        beat_last = 1'b0;
        beat_user = 1'b0;

        case (state)
            st_idle, st_payload: begin
                beat_valid = xfer;
                if (xfer) begin
                    if (!in_last) begin
                        crc_update = 1'b1;
                        state_next = st_payload;
                    end else if (in_user) begin
                        // aborted frame leaves without fcs
                        beat_last = 1'b1;
                        beat_user = 1'b1;
                        crc_restart = 1'b1;
                        state_next = st_idle;
                    end else begin
                        beat_data = fcs_word0;
                        beat_keep = fcs_keep0;
                        crc_restart = 1'b1;
                        if (fcs_keep1 == '0) begin
                            beat_last = 1'b1;
                            state_next = st_idle;
                        end else begin
                            // fcs spills into one extra beat
                            spill_load = 1'b1;
                            ready_next = 1'b0;
                            state_next = st_fcs;
                        end
                    end
                end
            end
            st_fcs: begin
                ready_next = 1'b0;
                beat_data = spill_data;
                beat_keep = spill_keep;
                beat_valid = 1'b1;
                beat_last = 1'b1;
                if (accept) begin
                    ready_next = accept_early;
                    state_next = st_idle;
                end
            end
            default: begin
                ready_next = 1'b0;
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            in_ready <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            in_ready <= ready_next;
            busy <= (state_next != st_idle);
        end
    end

    always_ff @(posedge clk) begin
        if (spill_load) begin
            spill_data <= fcs_word1;
            spill_keep <= fcs_keep1;
        end
    end

    // source must wait while the spill beat goes out
    a_no_ready_in_fcs: assert property (
        @(posedge clk) disable iff (rst) (state == st_fcs) |-> !in_ready
    ) else $error("in_ready high during fcs spill beat");

    a_keep_contiguous: assert property (
        @(posedge clk) disable iff (rst)
        xfer |-> (in_keep[0] && ((in_keep & keep_t'(in_keep + 1'b1)) == '0))
    ) else $error("accepted in_keep not contiguous from lane 0");

endmodule

`default_nettype wire

/* verilog/axis_skid_out.sv */
// Beat is taken only while accept is high; holds at most two beats under back-pressure
`default_nettype none
`timescale 1ns/1ns

module axis_skid_out (
    input  wire                      clk,
    input  wire                      rst,
    input  wire eth_fcs_pkg::beat_t  beat_data,
    input  wire eth_fcs_pkg::keep_t  beat_keep,
    input  wire                      beat_valid,
    input  wire                      beat_last,
    input  wire                      beat_user,
    output logic                     accept,
    output logic                     accept_early,
    output eth_fcs_pkg::beat_t       out_data,
    output eth_fcs_pkg::keep_t       out_keep,
    output logic                     out_valid,
    output logic                     out_last,
    output logic                     out_user,
    input  wire                      out_ready
);
    import eth_fcs_pkg::*;

    beat_t tmp_data;
    keep_t tmp_keep;
    logic  tmp_valid;
    logic  tmp_last;
    logic  tmp_user;

    logic  out_valid_next;
    logic  tmp_valid_next;
    logic  in_to_out;
    logic  in_to_tmp;
    logic  tmp_to_out;

    // room next cycle if the sink drains or nothing is held
    assign accept_early = out_ready || (!tmp_valid && !out_valid);

    always_comb begin
        out_valid_next = out_valid;
        tmp_valid_next = tmp_valid;
        in_to_out = 1'b0;
        in_to_tmp = 1'b0;
        tmp_to_out = 1'b0;

        if (accept) begin
            if (out_ready || !out_valid) begin
                out_valid_next = beat_valid;
                in_to_out = 1'b1;
            end else begin
                // park the beat while the output is stalled
                tmp_valid_next = beat_valid;
                in_to_tmp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            tmp_valid <= 1'b0;
            accept <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            tmp_valid <= tmp_valid_next;
            accept <= accept_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_data <= beat_data;
            out_keep <= beat_keep;
            out_last <= beat_last;
            out_user <= beat_user;
        end else if (tmp_to_out) begin
            out_data <= tmp_data;
            out_keep <= tmp_keep;
            out_last <= tmp_last;
            out_user <= tmp_user;
        end
        if (in_to_tmp) begin
            tmp_data <= beat_data;
            tmp_keep <= beat_keep;
            tmp_last <= beat_last;
            tmp_user <= beat_user;
        end
    end

    // temp only fills behind a stalled output beat
    a_tmp_behind_out: assert property (
        @(posedge clk) disable iff (rst) tmp_valid |-> out_valid
    ) else $error("holding register valid while output register empty");

endmodule

`default_nettype wire

/* verilog/eth_fcs_insert_64.sv */
// No minimum-length padding; a last beat with in_user set leaves aborted without FCS
`default_nettype none
`timescale 1ns/1ns

module eth_fcs_insert_64 (
    input  wire                      clk,
    input  wire                      rst,
    input  wire eth_fcs_pkg::beat_t  in_data,
    input  wire eth_fcs_pkg::keep_t  in_keep,
    input  wire                      in_valid,
    output logic                     in_ready,
    input  wire                      in_last,
    input  wire                      in_user,
    output eth_fcs_pkg::beat_t       out_data,
    output eth_fcs_pkg::keep_t       out_keep,
    output logic                     out_valid,
    input  wire                      out_ready,
    output logic                     out_last,
    output logic                     out_user,
    output logic                     busy
);
    import eth_fcs_pkg::*;

    beat_t crc_data;
    keep_t crc_keep;
    logic  crc_update;
    logic  crc_restart;
    crc_t  fcs;

    beat_t word0;
    beat_t word1;
    keep_t keep0;
    keep_t keep1;

    // internal stream into the output stage
    beat_t beat_data;
    keep_t beat_keep;
    logic  beat_valid;
    logic  beat_last;
    logic  beat_user;
    logic  accept;
    logic  accept_early;

    fcs_frame_ctrl fcs_frame_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .in_valid     (in_valid),
        .in_last      (in_last),
        .in_user      (in_user),
        .in_ready     (in_ready),
        .busy         (busy),
        .accept       (accept),
        .accept_early (accept_early),
        .fcs_word0    (word0),
        .fcs_keep0    (keep0),
        .fcs_word1    (word1),
        .fcs_keep1    (keep1),
        .crc_data     (crc_data),
        .crc_keep     (crc_keep),
        .crc_update   (crc_update),
        .crc_restart  (crc_restart),
        .beat_data    (beat_data),
        .beat_keep    (beat_keep),
        .beat_valid   (beat_valid),
        .beat_last    (beat_last),
        .beat_user    (beat_user)
    );

    fcs_crc_engine fcs_crc_engine_inst (
        .clk         (clk),
        .rst         (rst),
        .crc_data    (crc_data),
        .crc_keep    (crc_keep),
        .crc_update  (crc_update),
        .crc_restart (crc_restart),
        .fcs         (fcs)
    );

    fcs_place fcs_place_inst (
        .crc_data (crc_data),
        .crc_keep (crc_keep),
        .fcs      (fcs),
        .word0    (word0),
        .word1    (word1),
        .keep0    (keep0),
        .keep1    (keep1)
    );

    axis_skid_out axis_skid_out_inst (
        .clk          (clk),
        .rst          (rst),
        .beat_data    (beat_data),
        .beat_keep    (beat_keep),
        .beat_valid   (beat_valid),
        .beat_last    (beat_last),
        .beat_user    (beat_user),
        .accept       (accept),
        .accept_early (accept_early),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .out_valid    (out_valid),
        .out_last     (out_last),
        .out_user     (out_user),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

/* tests/tb_eth_fcs_insert_64.sv */
// Non-last beats are full; about one frame in six is aborted; out_ready thins in phases
`default_nettype none
`timescale 1ns/1ns

module tb_eth_fcs_insert_64;
    import eth_fcs_pkg::*;

    localparam int n_frames = 80;

    logic  clk = 1'b0;
    logic  rst = 1'b1;
    beat_t in_data = '0;
    keep_t in_keep = '0;
    logic  in_valid = 1'b0;
    logic  in_last = 1'b0;
    logic  in_user = 1'b0;
    logic  out_ready = 1'b0;
    beat_t out_data;
    keep_t out_keep;
    logic  in_ready, out_valid, out_last, out_user, busy;

    // expected frames in send order
    logic [7:0] exp_bytes[$];
    crc_t       exp_fcs[$];
    int         exp_len[$];
    int         exp_beats[$];
    bit         exp_abort[$];

    // frame now leaving the DUT
    int   cur_len, cur_beats, got;
    bit   cur_abort;
    crc_t rx_fcs;
    int   beat_no = 0;
    int   frames_done = 0;
    int   bp_mode = 0;
    bit   busy_due = 0;
    bit   frame_open = 0;
    int   err_data = 0, err_fcs = 0, err_keep = 0, err_flag = 0, err_other = 0;

    eth_fcs_insert_64 eth_fcs_insert_64_inst (.*);

    always #5 clk = ~clk;

    // reflected CRC-32 shifted in bit by bit, then inverted
    function automatic crc_t fcs_of(logic [7:0] q[$]);
        crc_t c;
        logic fb;
        c = 32'hFFFF_FFFF;
        foreach (q[i]) begin
            for (int j = 0; j < 8; j++) begin
                fb = c[0] ^ q[i][j];
                c = c >> 1;
                if (fb) begin
                    c = c ^ 32'hEDB8_8320;
                end
            end
        end
        return ~c;
    endfunction

    task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
        if (exp !== act) begin
            err_data++;
            $display("[ERROR] %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_fcs(string name, crc_t exp, crc_t act);
        if (exp !== act) begin
            err_fcs++;
            $display("[ERROR] %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_keep(string name, keep_t exp, keep_t act);
        if (exp !== act) begin
            err_keep++;
            $display("[ERROR] %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, bit exp, logic act);
        if (exp !== act) begin
            err_flag++;
            $display("[ERROR] %s: expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic send_frame();
        int len;
        int nb;
        int n;
        bit abort;
        logic [7:0] q[$];
        len = 1 + $urandom_range(39);
        nb = (len + 7) / 8;
        abort = ($urandom_range(5) == 0);
        for (int i = 0; i < len; i++) begin
            q.push_back(8'($urandom));
            exp_bytes.push_back(q[i]);
        end
        exp_len.push_back(len);
        exp_abort.push_back(abort);
        // fcs spills when the last beat holds more than four bytes
        exp_beats.push_back((!abort && len - 8 * (nb - 1) > 4) ? nb + 1 : nb);
        if (!abort) begin
            exp_fcs.push_back(fcs_of(q));
        end
        for (int b = 0; b < nb; b++) begin
            repeat ($urandom_range(2)) @(posedge clk) #1;
            n = (b == nb - 1) ? len - 8 * b : 8;
            // junk in the disabled lanes
            in_data = {$urandom, $urandom};
            for (int i = 0; i < n; i++) begin
                in_data[i*8 +: 8] = q[8*b + i];
            end
            in_keep = keep_t'((1 << n) - 1);
            in_last = (b == nb - 1);
            in_user = abort && in_last;
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready) begin
                @(negedge clk);
            end
            @(posedge clk) #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic take_beat();
        int n;
        string tag;
        if (beat_no == 0) begin
            if (exp_len.size() == 0) begin
                err_other++;
                $display("output beat arrived while no frame was outstanding");
                return;
            end
            cur_len = exp_len.pop_front();
            cur_abort = exp_abort.pop_front();
            cur_beats = exp_beats.pop_front();
            got = 0;
        end
        beat_no++;
        tag = $sformatf("frame %0d beat %0d", frames_done, beat_no);
        n = (cur_abort ? cur_len : cur_len + fcs_bytes) - got;
        n = (n > lanes) ? lanes : n;
        check_keep({tag, " keep"}, keep_t'((1 << n) - 1), out_keep);
        check_flag({tag, " last"}, beat_no == cur_beats, out_last);
        check_flag({tag, " user"}, cur_abort && beat_no == cur_beats, out_user);
        for (int i = 0; i < n; i++) begin
            if (got < cur_len) begin
                check_byte({tag, " data"}, exp_bytes.pop_front(), out_data[i*8 +: 8]);
            end else begin
                rx_fcs[8*(got - cur_len) +: 8] = out_data[i*8 +: 8];
            end
            got++;
        end
        if (out_last || beat_no >= cur_beats) begin
            if (!cur_abort) begin
                check_fcs({tag, " fcs"}, exp_fcs.pop_front(), rx_fcs);
            end
            frames_done++;
            beat_no = 0;
        end
    endtask

    // falling edge sees the values that the next rising edge transfers
    always @(negedge clk) begin
        if (busy_due) begin
            check_flag("busy inside frame", 1'b1, busy);
        end
        if (in_valid && in_ready) begin
            frame_open = !in_last;
            // a spill beat keeps busy up for at least one more cycle
            busy_due = !in_last || (!in_user && in_keep[4]);
        end else begin
            busy_due = frame_open;
        end
        if (out_valid && out_ready) begin
            take_beat();
        end
    end

    // ready gets sparser with each phase
    always @(posedge clk) begin
        #1;
        out_ready = (bp_mode == 0) || ($urandom_range(3) >= bp_mode);
    end

    initial begin
        #(n_frames * 60 * 10);
        $display("timeout: not all frames left the DUT in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'h98d39999));
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_flag("reset out_valid", 1'b0, out_valid);
        check_flag("reset busy", 1'b0, busy);
        @(negedge clk);
        check_flag("in_ready after reset", 1'b1, in_ready);
        @(posedge clk) #1;
        for (int f = 0; f < n_frames; f++) begin
            bp_mode = f * 4 / n_frames;
            send_frame();
        end
        wait (frames_done == n_frames);
        repeat (10) @(negedge clk);
        check_flag("idle busy", 1'b0, busy);
        check_flag("idle out_valid", 1'b0, out_valid);
        $display("errors: data %0d, fcs %0d, keep %0d, flag %0d, other %0d",
                 err_data, err_fcs, err_keep, err_flag, err_other);
        if (err_data + err_fcs + err_keep + err_flag + err_other == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
verilog/eth_fcs_pkg.sv
verilog/fcs_crc_engine.sv
verilog/fcs_place.sv
verilog/fcs_frame_ctrl.sv
verilog/axis_skid_out.sv
verilog/eth_fcs_insert_64.sv
tests/tb_eth_fcs_insert_64.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_eth_fcs_insert_64 -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"
if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
